// File: logic/msx_pkg.sv
package msx_pkg;

// address widths in bytes
localparam int DDR3_AW  = 28;
localparam int SDRAM_AW = 25;

// DDR3 layout written by the host
localparam logic [DDR3_AW-1:0] CONFIG_BASE = 28'h0100000;
localparam logic [DDR3_AW-1:0] ROM_BASE_A  = 28'h0200000;
localparam logic [DDR3_AW-1:0] ROM_BASE_B  = 28'h0400000;

// slot B starts here in SDRAM, slot A at 0
localparam logic [SDRAM_AW-1:0] ROM_SLOT_SIZE = 25'h0200000;

// low byte of ioctl_index
typedef enum logic [7:0] {
   IDX_CONFIG = 8'd0,
   IDX_ROM_A  = 8'd1,
   IDX_ROM_B  = 8'd2
} dl_index_t;

// config byte 0
typedef enum logic [7:0] {
   MSX1 = 8'd0,
   MSX2 = 8'd1
} msx_type_t;

typedef struct packed {
   logic        loaded;
   logic [23:0] size;   // bytes
   logic        fits;   // whole image lies inside SDRAM
} rom_info_t;

// sdram_size code to capacity in bytes
function automatic logic [27:0] sdram_capacity(input logic [1:0] code);
   case (code)
      2'd0:    return 28'h0800000;   // 8 MiB
      2'd1:    return 28'h1000000;   // 16 MiB
      default: return 28'h2000000;   // 32 MiB
   endcase
endfunction

endpackage

// File: logic/ddr3_rd_if.sv
`timescale 1ns/10ps

interface ddr3_rd_if
   import msx_pkg::*;
();

logic               request;   // held for a whole run of reads
logic               rd;        // one cycle, only while ready
logic [DDR3_AW-1:0] addr;
logic         [7:0] dout;      // valid when ready comes back
logic               ready;

modport master (
   output request, rd, addr,
   input  dout, ready
);

modport slave (
   input  request, rd, addr,
   output dout, ready
);

endinterface

// File: logic/ddr3_arbiter.sv
`timescale 1ns/10ps

module ddr3_arbiter
   import msx_pkg::*;
(
   input                      clk,
   input                      reset,
   ddr3_rd_if.slave           cfg,
   ddr3_rd_if.slave           ram,
   output logic [DDR3_AW-1:0] ddr3_addr,
   output logic               ddr3_rd,
   output logic               ddr3_request,
   input                [7:0] ddr3_dout,
   input                      ddr3_ready
);

typedef enum logic [1:0] {OWN_IDLE, OWN_CFG, OWN_RAM} owner_t;

owner_t owner;
logic   outstanding;   // a read was issued and its data is not back yet

always_ff @(posedge clk) begin
   if (reset) begin
      owner       <= OWN_IDLE;
      outstanding <= 1'b0;
   end else begin
      if (ddr3_rd)
         outstanding <= 1'b1;
      else if (ddr3_ready)
         outstanding <= 1'b0;

      if (!outstanding) begin
         case (owner)
            OWN_IDLE: begin
               if (cfg.request)
                  owner <= OWN_CFG;   // config reader wins
               else if (ram.request)
                  owner <= OWN_RAM;
            end
            OWN_CFG: if (!cfg.request) owner <= ram.request ? OWN_RAM : OWN_IDLE;
            OWN_RAM: if (!ram.request) owner <= cfg.request ? OWN_CFG : OWN_IDLE;
            default: owner <= OWN_IDLE;
         endcase
      end
   end
end

assign ddr3_request = (owner == OWN_CFG) ? cfg.request :
                      (owner == OWN_RAM) ? ram.request : 1'b0;
assign ddr3_rd      = (owner == OWN_CFG) ? cfg.rd :
                      (owner == OWN_RAM) ? ram.rd : 1'b0;
assign ddr3_addr    = (owner == OWN_RAM) ? ram.addr : cfg.addr;

// only the owner sees the memory
assign cfg.ready = (owner == OWN_CFG) && ddr3_ready;
assign ram.ready = (owner == OWN_RAM) && ddr3_ready;
assign cfg.dout  = (owner == OWN_CFG) ? ddr3_dout : 8'd0;
assign ram.dout  = (owner == OWN_RAM) ? ddr3_dout : 8'd0;

endmodule

// File: logic/store_rom_config.sv
`timescale 1ns/10ps

module store_rom_config
   import msx_pkg::*;
(
   input                   clk,
   input                   reset,
   input                   ioctl_download,
   input            [15:0] ioctl_index,
   input            [26:0] ioctl_addr,
   input                   rom_eject,
   input             [1:0] sdram_size,
   output rom_info_t       rom_info[2],
   output logic            update_request
);

dl_index_t   idx;
logic        dl_d;
logic        rom_active;   // current download is a cartridge image
logic        rom_slot;     // 0 = A, 1 = B
logic [26:0] max_addr;
logic [27:0] rom_end;      // one past the last SDRAM byte of the image
logic        dl_end;

assign idx     = dl_index_t'(ioctl_index[7:0]);
assign dl_end  = dl_d && !ioctl_download;
assign rom_end = {1'b0, max_addr} + 28'd1 + (rom_slot ? {3'd0, ROM_SLOT_SIZE} : 28'd0);

always_ff @(posedge clk) begin
   if (ioctl_download) begin
      if (!dl_d) begin
         max_addr <= ioctl_addr;
         rom_slot <= idx == IDX_ROM_B;
      end else if (ioctl_addr > max_addr) begin
         max_addr <= ioctl_addr;
      end
   end
end

always_ff @(posedge clk) begin
   if (reset) begin
      dl_d           <= 1'b0;
      rom_active     <= 1'b0;
      rom_info[0]    <= '0;
      rom_info[1]    <= '0;
      update_request <= 1'b0;
   end else begin
      dl_d           <= ioctl_download;
      update_request <= 1'b0;
      if (ioctl_download && !dl_d)
         rom_active <= idx == IDX_ROM_A || idx == IDX_ROM_B;

      if (rom_eject) begin
         rom_info[0]    <= '0;
         rom_info[1]    <= '0;
         update_request <= 1'b1;
      end else if (dl_end && rom_active) begin
         rom_info[rom_slot].loaded <= 1'b1;
         rom_info[rom_slot].size   <= max_addr[23:0] + 24'd1;
         rom_info[rom_slot].fits   <= rom_end <= sdram_capacity(sdram_size);
         update_request            <= 1'b1;
      end
   end
end

endmodule

// File: logic/store_msx_config.sv
`timescale 1ns/10ps

module store_msx_config
   import msx_pkg::*;
(
   input                   clk,
   input                   reset,
   input                   ioctl_download,
   input            [15:0] ioctl_index,
   ddr3_rd_if.master       ddr3,
   output msx_type_t       msx_type,
   output logic      [7:0] ram_mapper_count,
   output logic            need_reset,
   output logic            update_request
);

typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_WAIT} state_t;

state_t     state;
dl_index_t  idx;
logic       dl_d;
logic       cfg_dl;       // current download is the config blob
logic [1:0] byte_cnt;
msx_type_t  new_type;
logic [7:0] new_mapper;

assign idx          = dl_index_t'(ioctl_index[7:0]);
assign ddr3.request = state != ST_IDLE;
assign ddr3.rd      = (state == ST_READ) && ddr3.ready;
assign ddr3.addr    = CONFIG_BASE + {{(DDR3_AW-2){1'b0}}, byte_cnt};

// record bytes, applied together at the end of the run
always_ff @(posedge clk) begin
   if (state == ST_WAIT && ddr3.ready) begin
      if (byte_cnt == 2'd0)
         new_type <= (ddr3.dout == MSX2) ? MSX2 : MSX1;
      if (byte_cnt == 2'd1)
         new_mapper <= ddr3.dout;
   end
end

always_ff @(posedge clk) begin
   if (reset) begin
      state            <= ST_IDLE;
      dl_d             <= 1'b0;
      cfg_dl           <= 1'b0;
      byte_cnt         <= 2'd0;
      msx_type         <= MSX1;
      ram_mapper_count <= 8'd4;
      need_reset       <= 1'b0;
      update_request   <= 1'b0;
   end else begin
      dl_d           <= ioctl_download;
      need_reset     <= 1'b0;
      update_request <= 1'b0;
      if (ioctl_download)
         cfg_dl <= idx == IDX_CONFIG;

      case (state)
         ST_IDLE: begin
            if (dl_d && !ioctl_download && cfg_dl) begin
               byte_cnt <= 2'd0;
               state    <= ST_READ;
            end
         end
         ST_READ: if (ddr3.ready) state <= ST_WAIT;   // rd goes out this cycle
         ST_WAIT: begin
            if (ddr3.ready) begin
               if (byte_cnt == 2'd3) begin   // bytes 2 and 3 are reserved
                  state            <= ST_IDLE;
                  msx_type         <= new_type;
                  ram_mapper_count <= new_mapper;
                  need_reset       <= new_type != msx_type;
                  update_request   <= 1'b1;
               end else begin
                  byte_cnt <= byte_cnt + 2'd1;
                  state    <= ST_READ;
               end
            end
         end
         default: state <= ST_IDLE;
      endcase
   end
end

endmodule

// File: logic/upload_ram.sv
`timescale 1ns/10ps

module upload_ram
   import msx_pkg::*;
(
   input                       clk,
   input                       reset,
   input                       update_request,
   input rom_info_t            rom_info[2],
   ddr3_rd_if.master           ddr3,
   input                       sdram_ready,
   output logic                sdram_request,
   output logic [SDRAM_AW-1:0] sdram_addr,
   output logic          [7:0] sdram_din,
   output logic                sdram_we
);

typedef enum logic [2:0] {ST_IDLE, ST_CHECK, ST_READ, ST_WAIT, ST_WRITE} state_t;

state_t      state;
logic        pending;   // an update came in and no copy has started for it
logic        slot;      // 0 = A, 1 = B
logic [23:0] offset;
logic [23:0] next_offset;
logic  [7:0] data;
rom_info_t   cur;

assign cur         = rom_info[slot];
assign next_offset = offset + 24'd1;

assign ddr3.request  = state != ST_IDLE;
assign ddr3.rd       = (state == ST_READ) && ddr3.ready;
assign ddr3.addr     = (slot ? ROM_BASE_B : ROM_BASE_A) + {4'd0, offset};
assign sdram_request = state != ST_IDLE;
assign sdram_we      = (state == ST_WRITE) && sdram_ready;
assign sdram_addr    = (slot ? ROM_SLOT_SIZE : {SDRAM_AW{1'b0}}) + {1'b0, offset};
assign sdram_din     = data;

always_ff @(posedge clk) begin
   if (state == ST_WAIT && ddr3.ready)
      data <= ddr3.dout;
end

always_ff @(posedge clk) begin
   if (reset) begin
      state   <= ST_IDLE;
      pending <= 1'b0;
      slot    <= 1'b0;
      offset  <= 24'd0;
   end else begin
      if (update_request)
         pending <= 1'b1;
      else if (state == ST_IDLE && pending)
         pending <= 1'b0;

      case (state)
         ST_IDLE: begin
            if (pending) begin
               slot   <= 1'b0;
               offset <= 24'd0;
               state  <= ST_CHECK;
            end
         end
         ST_CHECK: begin
            offset <= 24'd0;
            if (cur.loaded && cur.fits && cur.size != 24'd0)
               state <= ST_READ;
            else if (slot)
               state <= ST_IDLE;
            else
               slot <= 1'b1;   // skip to slot B
         end
         ST_READ: if (ddr3.ready) state <= ST_WAIT;
         ST_WAIT: if (ddr3.ready) state <= ST_WRITE;
         ST_WRITE: begin
            if (sdram_ready) begin
               if (next_offset >= cur.size) begin
                  slot  <= 1'b1;
                  state <= slot ? ST_IDLE : ST_CHECK;
               end else begin
                  offset <= next_offset;
                  state  <= ST_READ;
               end
            end
         end
         default: state <= ST_IDLE;
      endcase
   end
end

endmodule

// File: logic/download.sv
`timescale 1ns/10ps

module download
   import msx_pkg::*;
(
   input                       clk,
   input                       reset,
   output logic                need_reset,
   input                       ioctl_download,
   input                [15:0] ioctl_index,
   input                [26:0] ioctl_addr,
   input                       rom_eject,
   input                       cart_changed,
   output logic  [DDR3_AW-1:0] ddr3_addr,
   output logic                ddr3_rd,
   output logic                ddr3_request,
   input                 [7:0] ddr3_dout,
   input                       ddr3_ready,
   input                       sdram_ready,
   output logic                sdram_request,
   output logic [SDRAM_AW-1:0] sdram_addr,
   output logic          [7:0] sdram_din,
   output logic                sdram_we,
   input                 [1:0] sdram_size,
   output rom_info_t           rom_info[2],
   output msx_type_t           msx_type,
   output logic          [7:0] ram_mapper_count
);

ddr3_rd_if cfg_bus();   // config reader, higher priority
ddr3_rd_if ram_bus();   // ROM copier

logic rom_update;
logic cfg_update;
logic update_request;

// any of these means SDRAM contents may be stale
assign update_request = cart_changed | rom_update | cfg_update;

ddr3_arbiter ddr3_arbiter (
   .clk          (clk),
   .reset        (reset),
   .cfg          (cfg_bus),
   .ram          (ram_bus),
   .ddr3_addr    (ddr3_addr),
   .ddr3_rd      (ddr3_rd),
   .ddr3_request (ddr3_request),
   .ddr3_dout    (ddr3_dout),
   .ddr3_ready   (ddr3_ready)
);

store_rom_config store_rom_config (
   .clk            (clk),
   .reset          (reset),
   .ioctl_download (ioctl_download),
   .ioctl_index    (ioctl_index),
   .ioctl_addr     (ioctl_addr),
   .rom_eject      (rom_eject),
   .sdram_size     (sdram_size),
   .rom_info       (rom_info),
   .update_request (rom_update)
);

store_msx_config store_msx_config (
   .clk              (clk),
   .reset            (reset),
   .ioctl_download   (ioctl_download),
   .ioctl_index      (ioctl_index),
   .ddr3             (cfg_bus),
   .msx_type         (msx_type),
   .ram_mapper_count (ram_mapper_count),
   .need_reset       (need_reset),
   .update_request   (cfg_update)
);

upload_ram upload_ram (
   .clk            (clk),
   .reset          (reset),
   .update_request (update_request),
   .rom_info       (rom_info),
   .ddr3           (ram_bus),
   .sdram_ready    (sdram_ready),
   .sdram_request  (sdram_request),
   .sdram_addr     (sdram_addr),
   .sdram_din      (sdram_din),
   .sdram_we       (sdram_we)
);

endmodule

// File: verif/ddr3_sdram_model.sv
`timescale 1ns/10ps

module ddr3_sdram_model
   import msx_pkg::*;
(
   input                       clk,
   input                       reset,
   input         [DDR3_AW-1:0] ddr3_addr,
   input                       ddr3_rd,
   output logic          [7:0] ddr3_dout,
   output logic                ddr3_ready,
   input        [SDRAM_AW-1:0] sdram_addr,
   input                 [7:0] sdram_din,
   input                       sdram_we,
   output logic                sdram_ready
);

logic         [7:0] ddr3_mem[logic [DDR3_AW-1:0]];   // what the host put in DDR3
logic         [7:0] sdram_mem[logic [SDRAM_AW-1:0]];
int                 write_count = 0;
int                 slot_b_writes = 0;
logic               rd_seen = 1'b0;
logic               we_seen = 1'b0;
logic [DDR3_AW-1:0] rd_addr = '0;
int                 ddr3_wait;
int                 sdram_wait;

function automatic logic [7:0] ddr3_byte(input logic [DDR3_AW-1:0] a);
   if (ddr3_mem.exists(a))
      return ddr3_mem[a];
   return a[7:0] ^ a[15:8] ^ a[23:16] ^ {4'h0, a[27:24]};   // never loaded
endfunction

function automatic logic [7:0] sdram_byte(input logic [SDRAM_AW-1:0] a);
   if (sdram_mem.exists(a))
      return sdram_mem[a];
   return 8'hxx;
endfunction

task automatic load_ddr3(input logic [DDR3_AW-1:0] a, input logic [7:0] d);
   ddr3_mem[a] = d;
endtask

// requests are taken at the rising edge
always @(posedge clk) begin
   rd_seen = ddr3_rd;
   we_seen = sdram_we;
   if (ddr3_rd)
      rd_addr = ddr3_addr;
   if (sdram_we) begin
      sdram_mem[sdram_addr] = sdram_din;
      write_count++;
      if (sdram_addr >= ROM_SLOT_SIZE)
         slot_b_writes++;
   end
end

// ready lines move on the falling edge
initial begin
   ddr3_dout   = 8'd0;
   ddr3_ready  = 1'b1;
   sdram_ready = 1'b1;
   ddr3_wait   = 0;
   sdram_wait  = 0;
   forever begin
      @(negedge clk);
      if (reset) begin
         ddr3_ready  = 1'b1;
         sdram_ready = 1'b1;
      end else begin
         if (rd_seen) begin
            ddr3_ready = 1'b0;
            ddr3_wait  = $urandom % 4;   // extra cycles before data
         end else if (!ddr3_ready) begin
            if (ddr3_wait == 0) begin
               ddr3_dout  = ddr3_byte(rd_addr);
               ddr3_ready = 1'b1;
            end else
               ddr3_wait = ddr3_wait - 1;
         end
         if (we_seen) begin
            sdram_ready = 1'b0;
            sdram_wait  = $urandom % 4;
         end else if (!sdram_ready) begin
            if (sdram_wait == 0)
               sdram_ready = 1'b1;
            else
               sdram_wait = sdram_wait - 1;
         end
      end
   end
end

endmodule

// File: verif/download_tb.sv
`timescale 1ns/10ps

module download_tb
   import msx_pkg::*;
();

localparam int WAIT_LIMIT = 20000;   // cycles per wait

logic                clk;
logic                reset;
logic                ioctl_download;
logic         [15:0] ioctl_index;
logic         [26:0] ioctl_addr;
logic                rom_eject;
logic                cart_changed;
logic          [1:0] sdram_size;
logic                need_reset;
logic  [DDR3_AW-1:0] ddr3_addr;
logic                ddr3_rd;
logic                ddr3_request;
logic          [7:0] ddr3_dout;
logic                ddr3_ready;
logic                sdram_ready;
logic                sdram_request;
logic [SDRAM_AW-1:0] sdram_addr;
logic          [7:0] sdram_din;
logic                sdram_we;
rom_info_t           rom_info[2];
msx_type_t           msx_type;
logic          [7:0] ram_mapper_count;

int error_count;
int pass_count;
int fail_count;
int reset_pulses = 0;   // need_reset pulses since start
bit timed_out;

download dut (.*);
ddr3_sdram_model mem (.*);

initial begin
   clk = 1'b0;
   forever #2 clk = ~clk;
end

always @(negedge clk)
   if (need_reset) reset_pulses++;

task automatic expect_equal(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
   assert (got === exp) else begin
      $display("FAILED at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
      error_count++;
   end
endtask

task automatic report_timeout(input string what);
   $display("timeout at %0t ns: %s did not happen in time", $time, what);
   error_count++;
   timed_out = 1'b1;
endtask

task automatic wait_busy(input string what);
   int n;
   n = 0;
   while (!(ddr3_request || sdram_request) && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
   end
   if (!(ddr3_request || sdram_request))
      report_timeout(what);
endtask

// a restarted copy idles for at most two cycles
task automatic wait_idle(input string what);
   int n;
   int quiet;
   n = 0;
   quiet = 0;
   while (quiet < 4 && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
      quiet = (ddr3_request || sdram_request) ? 0 : quiet + 1;
   end
   if (quiet < 4)
      report_timeout(what);
endtask

// only the highest ioctl address counts so a short stream will do
task automatic download_image(input dl_index_t index, input logic [26:0] last_addr);
   @(negedge clk);
   ioctl_index    = {8'h00, index};
   ioctl_download = 1'b1;
   ioctl_addr     = 27'd0;
   @(negedge clk);
   ioctl_addr = last_addr >> 1;
   @(negedge clk);
   ioctl_addr = last_addr;
   @(negedge clk);
   ioctl_download = 1'b0;
endtask

task automatic load_rom(input logic [DDR3_AW-1:0] base, input int n);
   for (int i = 0; i < n; i++)
      mem.load_ddr3(base + DDR3_AW'(i), 8'($urandom));
endtask

task automatic load_config(input msx_type_t kind, input logic [7:0] count);
   mem.load_ddr3(CONFIG_BASE, kind);
   mem.load_ddr3(CONFIG_BASE + 28'd1, count);
   mem.load_ddr3(CONFIG_BASE + 28'd2, 8'($urandom));   // reserved
   mem.load_ddr3(CONFIG_BASE + 28'd3, 8'($urandom));
endtask

task automatic compare_copy(input logic [DDR3_AW-1:0] src, input logic [SDRAM_AW-1:0] dst,
                            input int n);
   logic [SDRAM_AW-1:0] a;
   for (int i = 0; i < n; i++) begin
      a = dst + SDRAM_AW'(i);
      expect_equal($sformatf("sdram[%0h]", a), 32'(mem.sdram_byte(a)),
                   32'(mem.ddr3_byte(src + DDR3_AW'(i))));
   end
endtask

task automatic check_rom(input int slot, input logic loaded, input logic [23:0] size,
                         input logic fits);
   expect_equal($sformatf("rom_info[%0d].loaded", slot), 32'(rom_info[slot].loaded),
                32'(loaded));
   expect_equal($sformatf("rom_info[%0d].size", slot), 32'(rom_info[slot].size), 32'(size));
   expect_equal($sformatf("rom_info[%0d].fits", slot), 32'(rom_info[slot].fits), 32'(fits));
endtask

task automatic finish_test(input string name, input int errors_before);
   if (error_count == errors_before) begin
      pass_count++;
      $display("test %s: ok", name);
   end else begin
      fail_count++;
      $display("test %s: %0d errors", name, error_count - errors_before);
   end
endtask

task automatic test_reset();
   int errs;
   errs = error_count;
   reset = 1'b1;
   repeat (5) @(negedge clk);
   reset = 1'b0;
   expect_equal("ddr3_rd", 32'(ddr3_rd), 0);
   expect_equal("ddr3_request", 32'(ddr3_request), 0);
   expect_equal("sdram_we", 32'(sdram_we), 0);
   expect_equal("sdram_request", 32'(sdram_request), 0);
   expect_equal("need_reset", 32'(need_reset), 0);
   check_rom(0, 1'b0, 24'd0, 1'b0);
   check_rom(1, 1'b0, 24'd0, 1'b0);
   expect_equal("msx_type", 32'(msx_type), 32'(MSX1));
   expect_equal("ram_mapper_count", 32'(ram_mapper_count), 4);
   finish_test("reset", errs);
endtask

task automatic test_config();
   int errs;
   int pulses;
   errs = error_count;
   load_config(MSX2, 8'd8);
   for (int round = 0; round < 2; round++) begin   // second round repeats the same record
      pulses = reset_pulses;
      download_image(IDX_CONFIG, 27'd3);
      wait_busy("config read start");
      wait_idle("config read end");
      expect_equal("msx_type", 32'(msx_type), 32'(MSX2));
      expect_equal("ram_mapper_count", 32'(ram_mapper_count), 8);
      expect_equal("need_reset pulses", reset_pulses - pulses, 32'(round == 0));
   end
   finish_test("config", errs);
endtask

task automatic test_rom_a();
   int errs;
   int writes;
   errs = error_count;
   writes = mem.write_count;
   load_rom(ROM_BASE_A, 300);
   download_image(IDX_ROM_A, 27'd299);
   wait_busy("ROM A copy start");
   check_rom(0, 1'b1, 24'd300, 1'b1);
   wait_idle("ROM A copy end");
   compare_copy(ROM_BASE_A, '0, 300);
   expect_equal("sdram writes", mem.write_count - writes, 300);
   finish_test("rom A", errs);
endtask

task automatic test_rom_b();
   int errs;
   int upper;
   errs = error_count;
   upper = mem.slot_b_writes;
   sdram_size = 2'd0;
   download_image(IDX_ROM_B, 27'h6fffff);   // 7 MiB runs past 8 MiB from slot B
   wait_busy("ROM B update");
   check_rom(1, 1'b1, 24'h700000, 1'b0);
   wait_idle("ROM B update end");
   expect_equal("slot B writes", mem.slot_b_writes - upper, 0);
   load_rom(ROM_BASE_B, 64);
   download_image(IDX_ROM_B, 27'd63);
   wait_busy("ROM B copy start");
   check_rom(1, 1'b1, 24'd64, 1'b1);
   wait_idle("ROM B copy end");
   compare_copy(ROM_BASE_B, ROM_SLOT_SIZE, 64);
   compare_copy(ROM_BASE_A, '0, 300);
   finish_test("rom B", errs);
endtask

task automatic test_shared_port();
   int errs;
   int pulses;
   errs = error_count;
   pulses = reset_pulses;
   load_rom(ROM_BASE_A, 300);   // fresh bytes so the old copy no longer matches
   load_config(MSX1, 8'd16);
   download_image(IDX_ROM_A, 27'd299);
   wait_busy("ROM A copy start");
   download_image(IDX_CONFIG, 27'd3);
   expect_equal("sdram_request", 32'(sdram_request), 1);
   wait_idle("copy and config end");
   expect_equal("msx_type", 32'(msx_type), 32'(MSX1));
   expect_equal("ram_mapper_count", 32'(ram_mapper_count), 16);
   expect_equal("need_reset pulses", reset_pulses - pulses, 1);
   compare_copy(ROM_BASE_A, '0, 300);
   compare_copy(ROM_BASE_B, ROM_SLOT_SIZE, 64);
   finish_test("shared port", errs);
endtask

task automatic test_eject();
   int errs;
   int writes;
   errs = error_count;
   writes = mem.write_count;
   rom_eject = 1'b1;
   @(negedge clk);
   rom_eject = 1'b0;
   wait_busy("eject update");
   wait_idle("eject update end");
   expect_equal("rom_info[0].loaded", 32'(rom_info[0].loaded), 0);
   expect_equal("rom_info[1].loaded", 32'(rom_info[1].loaded), 0);
   cart_changed = 1'b1;
   @(negedge clk);
   cart_changed = 1'b0;
   wait_busy("cart change update");
   wait_idle("cart change update end");
   expect_equal("sdram writes", mem.write_count - writes, 0);
   finish_test("eject", errs);
endtask

task automatic run_all();
   test_reset();
   test_config();
   test_rom_a();
   test_rom_b();
   test_shared_port();
   test_eject();
endtask

initial begin
   reset          = 1'b1;
   ioctl_download = 1'b0;
   ioctl_index    = 16'd0;
   ioctl_addr     = 27'd0;
   rom_eject      = 1'b0;
   cart_changed   = 1'b0;
   sdram_size     = 2'd2;
   error_count    = 0;
   pass_count     = 0;
   fail_count     = 0;
   timed_out      = 1'b0;
   void'($urandom(32'hcca0));
   run_all();
   $display("tests passed: %0d, tests failed: %0d, failed checks: %0d",
            pass_count, fail_count, error_count);
   if (fail_count == 0 && !timed_out)
      $display("** PASS **");
   else
      $display("** FAIL **");
   $finish;
end

endmodule

// File: download.f
logic/msx_pkg.sv
logic/ddr3_rd_if.sv
logic/ddr3_arbiter.sv
logic/store_rom_config.sv
logic/store_msx_config.sv
logic/upload_ram.sv
logic/download.sv
verif/ddr3_sdram_model.sv
verif/download_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module download_tb \
   -f download.f --Mdir obj_dir -o download_sim

./obj_dir/download_sim > sim.log 2>&1
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
   exit 1
fi
exit 0
